// File: flist.f
verilog/riscv_pkg.sv
verilog/core_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/rr_stage.sv
verilog/exe_stage.sv
verilog/control_unit.sv
verilog/datapath.sv
verification/tb_datapath_assertions.sv
verification/tb_datapath.sv

// File: Makefile
# Verilator build and run for the datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_datapath
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^STATUS: PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_datapath.sv
/*
 * Testbench for the five-stage datapath
 * random programs from an xorshift generator, APB memory with wait states,
 * an ISA reference model and an in-order check of the commit trace
 */
module tb_datapath
    import riscv_pkg::*, core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_TESTS    = 5;
    localparam int          PROG_LEN     = 48;
    localparam int          ROM_WORDS    = PROG_LEN + 8;
    localparam int          MAX_WAIT     = 3;
    localparam int          TIMEOUT_NS   =
        NUM_TESTS * (ROM_WORDS * (MAX_WAIT + 8) + RESET_CYCLES + 10) * CLK_PERIOD;
    localparam logic [31:0] RESET_ADDR   = 32'h0000_0100;
    localparam instr_t      NOP          = 32'h0000_0013;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic            clk_i;
    logic            rstn_i;
    logic [XLEN-1:0] imem_addr;
    instr_t          imem_rdata;
    apb_req_t        apb_req;
    apb_resp_t       apb_resp = '0;
    commit_t         commit;

    instr_t      rom [ROM_WORDS];
    logic [31:0] dmem [64];
    logic [31:0] model_mem [64];
    logic [31:0] rng_state = 32'h34b4_ec5c;
    commit_t     exp_commits [$];
    store_t      exp_stores [$];
    int          errors;
    int          wait_cnt;
    int          rom_idx;

    datapath uut (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (RESET_ADDR),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .apb_o        (apb_req),
        .apb_i        (apb_resp),
        .commit_o     (commit)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // outside the ROM the fetch sees no-ops
    assign rom_idx    = int'((imem_addr - RESET_ADDR) >> 2);
    assign imem_rdata = (imem_addr >= RESET_ADDR && rom_idx < ROM_WORDS) ? rom[rom_idx] : NOP;

    function automatic logic [31:0] rand_next();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // random register or immediate ALU operation including LUI
    function automatic instr_t rand_alu(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        logic [31:0] r;
        r = rand_next();
        case (r % 11)
            0: return enc_r(7'h00, rs2, rs1, 3'd0, rd);
            1: return enc_r(7'h20, rs2, rs1, 3'd0, rd);
            2: return enc_r(7'h00, rs2, rs1, 3'd2, rd);
            3: return enc_r(7'h00, rs2, rs1, 3'd4, rd);
            4: return enc_r(7'h00, rs2, rs1, 3'd6, rd);
            5: return enc_r(7'h00, rs2, rs1, 3'd7, rd);
            6: return enc_i(r[31:20], rs1, 3'd0, rd, 7'b0010011);
            7: return enc_i(r[31:20], rs1, 3'd4, rd, 7'b0010011);
            8: return enc_i(r[31:20], rs1, 3'd6, rd, 7'b0010011);
            9: return enc_i(r[31:20], rs1, 3'd7, rd, 7'b0010011);
            default: return {r[31:12], rd, 7'b0110111};
        endcase
    endfunction

    // kind 0 alu, 1 dense deps, 2 memory, 3 control flow, 4 mixed
    task automatic gen_program(input int kind);
        logic [4:0]  last_rd [3];
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] sel;
        logic [11:0] off;
        logic [12:0] boff;
        last_rd = '{5'd1, 5'd2, 5'd3};
        // seed x1 to x7 since the register file has no reset
        for (int i = 0; i < 7; i++) begin
            rom[i] = enc_i(12'(rand_next() >> 20), 5'd0, 3'd0, 5'(i + 1), 7'b0010011);
        end
        for (int i = 7; i < PROG_LEN; i++) begin
            rd  = 5'(rand_next() % 8);
            rs1 = 5'(rand_next() % 8);
            rs2 = 5'(rand_next() % 8);
            if (kind == 1 || kind == 4) begin
                rs1 = last_rd[rand_next() % 3];
                rs2 = last_rd[rand_next() % 3];
            end
            sel  = rand_next() % 8;
            off  = 12'((rand_next() % 64) * 4);
            boff = 13'((rand_next() % 4 + 1) * 4);
            rom[i] = rand_alu(rd, rs1, rs2);
            if ((kind == 2 && sel < 3) || (kind == 4 && sel == 0)) begin
                rom[i] = enc_i(off, 5'd0, 3'd2, rd, 7'b0000011);
            end else if ((kind == 2 && sel < 5) || (kind == 4 && sel == 1)) begin
                rom[i] = enc_s(off, rs2, 5'd0);
            end else if ((kind == 3 && sel < 2) || (kind == 4 && sel == 2)) begin
                if (rand_next() % 2 == 0) begin
                    rs2 = rs1;
                end
                rom[i] = enc_b(boff, rs2, rs1, 3'(rand_next() % 2));
            end else if ((kind == 3 && sel == 2) || (kind == 4 && sel == 3)) begin
                rom[i] = enc_j(21'(boff), rd);
            end
            last_rd = '{rd, last_rd[0], last_rd[1]};
        end
        for (int i = PROG_LEN; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
    endtask

    // ISA interpreter that fills the expected commit and store queues
    task automatic run_model();
        logic [31:0] regs [8];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next_pc;
        instr_t      ins;
        commit_t     c;
        regs = '{default: '0};
        pc   = RESET_ADDR;
        while (pc < RESET_ADDR + 32'(ROM_WORDS * 4)) begin
            ins     = rom[(pc - RESET_ADDR) >> 2];
            a       = regs[ins[17:15]];
            b       = regs[ins[22:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = pc + 4;
            res     = '0;
            c       = '{valid: 1'b1, pc: pc, rd: ins[11:7], reg_we: 1'b1, data: '0};
            case (ins[6:0])
                7'b0110011: begin
                    case (ins[14:12])
                        3'd0: res = ins[30] ? a - b : a + b;
                        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: res = a ^ b;
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: begin
                    case (ins[14:12])
                        3'd0: res = a + imm_i;
                        3'd4: res = a ^ imm_i;
                        3'd6: res = a | imm_i;
                        default: res = a & imm_i;
                    endcase
                end
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0000011: res = model_mem[(a + imm_i) >> 2 & 32'h3f];
                7'b0100011: begin
                    c.reg_we = 1'b0;
                    exp_stores.push_back('{
                        addr: (a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) & ~32'h3,
                        data: b});
                    model_mem[(a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2 & 32'h3f] = b;
                end
                7'b1100011: begin
                    c.reg_we = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                default: begin
                    res     = pc + 4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
            endcase
            c.data = res;
            if (c.reg_we && ins[11:7] != 5'd0) begin
                regs[ins[9:7]] = res;
            end
            exp_commits.push_back(c);
            pc = next_pc;
        end
    endtask

    // APB memory with wait states drawn in the setup cycle
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            apb_resp = '0;
            wait_cnt = 0;
        end else begin
            #1;
            apb_resp.pready = 1'b0;
            if (apb_req.psel && !apb_req.penable) begin
                wait_cnt = int'(rand_next() % (MAX_WAIT + 1));
            end else if (apb_req.psel && apb_req.penable) begin
                if (wait_cnt == 0) begin
                    apb_resp.pready = 1'b1;
                    apb_resp.prdata = dmem[apb_req.paddr[7:2]];
                    if (apb_req.pwrite) begin
                        dmem[apb_req.paddr[7:2]] = apb_req.pwdata;
                        if (exp_stores.size() == 0) begin
                            $display("unexpected store of %h to address %h at %0t ns",
                                     apb_req.pwdata, apb_req.paddr, $time);
                            errors++;
                        end else begin
                            check("store address", apb_req.paddr, exp_stores[0].addr);
                            check("store data", apb_req.pwdata, exp_stores[0].data);
                            void'(exp_stores.pop_front());
                        end
                    end
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the commit trace stopped before all expected commits arrived");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        string   names [NUM_TESTS];
        int      passed;
        int      failed;
        int      errs_before;
        int      n_commits;
        commit_t exp;
        names  = '{"alu", "dependences", "load_store", "branch_jal", "mixed"};
        passed = 0;
        failed = 0;
        errors = 0;
        rstn_i = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = errors;
            rstn_i      = 1'b0;
            for (int i = 0; i < 64; i++) begin
                dmem[i]      = 32'hc0de_0000 ^ (i * 32'h0101_0101) ^ (i << 2);
                model_mem[i] = dmem[i];
            end
            exp_commits.delete();
            exp_stores.delete();
            gen_program(t);
            run_model();
            n_commits = exp_commits.size();
            repeat (RESET_CYCLES) @(posedge clk_i);
            #1;
            rstn_i = 1'b1;
            check("first fetch address", imem_addr, RESET_ADDR);
            check("commit valid after reset", 32'(commit.valid), 32'd0);
            check("psel after reset", 32'(apb_req.psel), 32'd0);
            while (exp_commits.size() > 0) begin
                @(posedge clk_i);
                #1;
                if (commit.valid) begin
                    exp = exp_commits.pop_front();
                    check("commit pc", commit.pc, exp.pc);
                    check("commit reg_we", 32'(commit.reg_we), 32'(exp.reg_we));
                    if (exp.reg_we) begin
                        check("commit rd", 32'(commit.rd), 32'(exp.rd));
                        check("commit data", commit.data, exp.data);
                    end
                end
            end
            if (exp_stores.size() != 0) begin
                $display("%0d expected stores never appeared on the APB bus", exp_stores.size());
                errors++;
            end
            if (errors == errs_before) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d %s: %0d commits, %0d errors", t, names[t], n_commits,
                     errors - errs_before);
        end
        $display("tests passed %0d, failed %0d", passed, failed);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/tb_datapath_assertions.sv
/*
 * APB protocol checks on the execute stage requester
 */
module tb_datapath_assertions
    import core_pkg::*;
(
    input logic      clk_i,
    input logic      rstn_i,
    input apb_req_t  apb_o,
    input apb_resp_t apb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // access phase only after a selected cycle
    penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rstn_i)
        apb_o.penable |-> (apb_o.psel && $past(apb_o.psel)))
        else $error("penable high without psel in this and the previous cycle");

    setup_then_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (apb_o.psel && !apb_o.penable) |=> (apb_o.psel && apb_o.penable))
        else $error("setup cycle not followed by access");

    // request fields hold until pready
    request_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (apb_o.psel && !(apb_o.penable && apb_i.pready)) |=>
        ($stable(apb_o.paddr) && $stable(apb_o.pwrite) && $stable(apb_o.pwdata)))
        else $error("APB request changed before completion");

    idle_after_done: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (apb_o.psel && apb_o.penable && apb_i.pready) |=> !apb_o.psel)
        else $error("psel still high after completed transfer");

endmodule

bind exe_stage tb_datapath_assertions apb_checker (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .apb_o  (apb_o),
    .apb_i  (apb_i)
);

// File: verilog/datapath.sv
/*
 * RV32 five-stage integer datapath, stages if, id, rr, ex and wb
 * connects the stages to the control unit, closes the wb path
 * and exposes every retiring instruction on the commit port
 */
module datapath
    import riscv_pkg::*, core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic [XLEN-1:0] reset_addr_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  instr_t          imem_rdata_i,
    output apb_req_t        apb_o,
    input  apb_resp_t       apb_i,
    output commit_t         commit_o
);

    if_id_t          fetch;
    id_rr_t          decode;
    rr_exe_t         operands;
    exe_wb_t         wb;
    bypass_t         bypass;
    redirect_t       redirect;
    pipeline_ctrl_t  ctrl;
    pipeline_flush_t flush;
    logic            mem_busy;
    logic            wb_we;

    control_unit control_unit_inst (
        .mem_busy_i (mem_busy),
        .redirect_i (redirect),
        .ctrl_o     (ctrl),
        .flush_o    (flush)
    );

    if_stage if_stage_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .stall_i      (ctrl.stall_if),
        .flush_i      (flush.flush_if),
        .redirect_i   (redirect),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .fetch_o      (fetch)
    );

    id_stage id_stage_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .stall_i  (ctrl.stall_id),
        .flush_i  (flush.flush_id),
        .fetch_i  (fetch),
        .decode_o (decode)
    );

    rr_stage rr_stage_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .stall_i    (ctrl.stall_rr),
        .flush_i    (flush.flush_rr),
        .decode_i   (decode),
        .wb_we_i    (wb_we),
        .wb_rd_i    (wb.rd),
        .wb_data_i  (wb.result),
        .operands_o (operands)
    );

    exe_stage exe_stage_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .stall_i    (ctrl.stall_exe),
        .operands_i (operands),
        .bypass_i   (bypass),
        .apb_o      (apb_o),
        .apb_i      (apb_i),
        .mem_busy_o (mem_busy),
        .redirect_o (redirect),
        .result_o   (wb)
    );

    // wb stage
    assign wb_we = wb.valid && wb.reg_we;

    assign bypass.valid = wb_we;
    assign bypass.rd    = wb.rd;
    assign bypass.data  = wb.result;

    // commit trace
    assign commit_o.valid  = wb.valid;
    assign commit_o.pc     = wb.pc;
    assign commit_o.rd     = wb.rd;
    assign commit_o.reg_we = wb.reg_we;
    assign commit_o.data   = wb.result;

endmodule

// File: verilog/control_unit.sv
/*
 * Pipeline control
 * stalls the front stages on a pending memory access and
 * flushes the younger stages on a taken branch or JAL
 */
module control_unit
    import core_pkg::*;
(
    input  logic            mem_busy_i,
    input  redirect_t       redirect_i,
    output pipeline_ctrl_t  ctrl_o,
    output pipeline_flush_t flush_o
);

    logic do_flush;

    // busy has priority, a branch is never the memory op in ex
    assign do_flush = redirect_i.taken && !mem_busy_i;

    assign ctrl_o.stall_if  = mem_busy_i;
    assign ctrl_o.stall_id  = mem_busy_i;
    assign ctrl_o.stall_rr  = mem_busy_i;
    assign ctrl_o.stall_exe = mem_busy_i;

    assign flush_o.flush_if = do_flush;
    assign flush_o.flush_id = do_flush;
    assign flush_o.flush_rr = do_flush;

endmodule

// File: verilog/exe_stage.sv
/*
 * Execute stage
 * operand bypass, ALU, branch resolution, APB requester for LW and SW
 * and the EXE/WB register
 */
module exe_stage
    import riscv_pkg::*, core_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      stall_i,
    input  rr_exe_t   operands_i,
    input  bypass_t   bypass_i,
    output apb_req_t  apb_o,
    input  apb_resp_t apb_i,
    output logic      mem_busy_o,
    output redirect_t redirect_o,
    output exe_wb_t   result_o
);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    id_rr_t          instr;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] wb_value;
    logic            mem_op;
    logic            mem_done;
    apb_state_e      state_q;
    logic            pwrite_q;
    logic [XLEN-1:0] paddr_q;
    logic [XLEN-1:0] pwdata_q;

    assign instr = operands_i.instr;

    // wb result overrides a stale operand
    assign op_a = (bypass_i.valid && bypass_i.rd != '0 && bypass_i.rd == instr.rs1) ?
                  bypass_i.data : operands_i.rs1_data;
    assign op_b = (bypass_i.valid && bypass_i.rd != '0 && bypass_i.rd == instr.rs2) ?
                  bypass_i.data : operands_i.rs2_data;
    assign alu_b = instr.use_imm ? instr.imm : op_b;

    always_comb begin
        case (instr.alu_op)
            ALU_SUB:    alu_res = op_a - alu_b;
            ALU_AND:    alu_res = op_a & alu_b;
            ALU_OR:     alu_res = op_a | alu_b;
            ALU_XOR:    alu_res = op_a ^ alu_b;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = op_a + alu_b;
        endcase
    end

    // branches compare rs1 with rs2 and always target pc + imm
    assign redirect_o.taken  = instr.valid &&
                               (instr.is_jal ||
                                (instr.is_branch && ((op_a == op_b) != instr.branch_ne)));
    assign redirect_o.target = instr.pc + instr.imm;

    // APB requester
    // the idle cycle before setup also separates back-to-back transfers
    assign mem_op     = instr.valid && (instr.is_load || instr.is_store);
    assign mem_done   = (state_q == APB_ACCESS) && apb_i.pready;
    assign mem_busy_o = mem_op && !mem_done;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= APB_IDLE;
        end else begin
            case (state_q)
                APB_IDLE:   state_q <= mem_op ? APB_SETUP : APB_IDLE;
                APB_SETUP:  state_q <= APB_ACCESS;
                APB_ACCESS: state_q <= apb_i.pready ? APB_IDLE : APB_ACCESS;
                default:    state_q <= APB_IDLE;
            endcase
        end
    end

    // operands are sampled while the wb bypass is still valid
    always_ff @(posedge clk_i) begin
        if (state_q == APB_IDLE && mem_op) begin
            pwrite_q <= instr.is_store;
            paddr_q  <= {alu_res[XLEN-1:2], 2'b00};
            pwdata_q <= op_b;
        end
    end

    assign apb_o.psel    = (state_q != APB_IDLE);
    assign apb_o.penable = (state_q == APB_ACCESS);
    assign apb_o.pwrite  = pwrite_q;
    assign apb_o.paddr   = paddr_q;
    assign apb_o.pwdata  = pwdata_q;

    assign wb_value = instr.is_load ? apb_i.prdata :
                      instr.is_jal  ? instr.pc + XLEN'(4) :
                                      alu_res;

    // bubble into wb while the memory access is pending
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            result_o.valid <= 1'b0;
        end else if (stall_i) begin
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid  <= instr.valid;
            result_o.pc     <= instr.pc;
            result_o.rd     <= instr.rd;
            result_o.reg_we <= instr.reg_we;
            result_o.result <= wb_value;
        end
    end

endmodule

// File: verilog/rr_stage.sv
/*
 * Register read stage
 * 32-entry register file with write-through and the RR/EXE register
 */
module rr_stage
    import riscv_pkg::*, core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  id_rr_t                decode_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output rr_exe_t               operands_o
);

    logic [XLEN-1:0] regs_q [32];
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (wb_we_i && wb_rd_i != '0) begin
            regs_q[wb_rd_i] <= wb_data_i;
        end
    end

    // same-cycle write is forwarded to the read ports
    assign rs1_data = (decode_i.rs1 == '0)                   ? '0 :
                      (wb_we_i && wb_rd_i == decode_i.rs1) ? wb_data_i :
                                                               regs_q[decode_i.rs1];
    assign rs2_data = (decode_i.rs2 == '0)                   ? '0 :
                      (wb_we_i && wb_rd_i == decode_i.rs2) ? wb_data_i :
                                                               regs_q[decode_i.rs2];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            operands_o.instr.valid <= 1'b0;
        end else if (flush_i) begin
            operands_o.instr.valid <= 1'b0;
        end else if (!stall_i) begin
            operands_o.instr    <= decode_i;
            operands_o.rs1_data <= rs1_data;
            operands_o.rs2_data <= rs2_data;
        end
    end

endmodule

// File: verilog/id_stage.sv
/*
 * Instruction decode stage
 * field decode, immediate generation and the ID/RR register
 */
module id_stage
    import riscv_pkg::*, core_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   stall_i,
    input  logic   flush_i,
    input  if_id_t fetch_i,
    output id_rr_t decode_o
);

    id_rr_t     decode_d;
    instr_t     instr;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign instr  = fetch_i.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        decode_d           = '0;
        decode_d.valid     = fetch_i.valid;
        decode_d.pc        = fetch_i.pc;
        decode_d.rs1       = instr[19:15];
        decode_d.rs2       = instr[24:20];
        decode_d.rd        = instr[11:7];
        decode_d.alu_op    = ALU_ADD;
        decode_d.branch_ne = funct3[0];
        case (opcode_t'(instr[6:0]))
            OPC_OP: begin
                decode_d.reg_we = (funct7 == F7_BASE) ||
                                  (funct7 == F7_SUB && funct3 == F3_ADD_SUB);
                case (funct3)
                    F3_ADD_SUB: decode_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLT:     decode_d.alu_op = ALU_SLT;
                    F3_XOR:     decode_d.alu_op = ALU_XOR;
                    F3_OR:      decode_d.alu_op = ALU_OR;
                    F3_AND:     decode_d.alu_op = ALU_AND;
                    default:    decode_d.reg_we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                decode_d.use_imm = 1'b1;
                decode_d.imm     = {{20{instr[31]}}, instr[31:20]};
                decode_d.reg_we  = 1'b1;
                case (funct3)
                    F3_ADD_SUB: decode_d.alu_op = ALU_ADD;
                    F3_XOR:     decode_d.alu_op = ALU_XOR;
                    F3_OR:      decode_d.alu_op = ALU_OR;
                    F3_AND:     decode_d.alu_op = ALU_AND;
                    default:    decode_d.reg_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                decode_d.use_imm = 1'b1;
                decode_d.imm     = {instr[31:12], 12'b0};
                decode_d.alu_op  = ALU_PASS_B;
                decode_d.reg_we  = 1'b1;
            end
            OPC_LOAD: begin
                decode_d.use_imm = 1'b1;
                decode_d.imm     = {{20{instr[31]}}, instr[31:20]};
                decode_d.is_load = (funct3 == F3_WORD);
                decode_d.reg_we  = (funct3 == F3_WORD);
            end
            OPC_STORE: begin
                decode_d.use_imm  = 1'b1;
                decode_d.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                decode_d.is_store = (funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                decode_d.imm       = {{20{instr[31]}}, instr[7], instr[30:25],
                                      instr[11:8], 1'b0};
                decode_d.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                decode_d.imm    = {{12{instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
                decode_d.is_jal = 1'b1;
                decode_d.reg_we = 1'b1;
            end
            // anything else retires as a no-op
            default: decode_d.reg_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            decode_o.valid <= 1'b0;
        end else if (flush_i) begin
            decode_o.valid <= 1'b0;
        end else if (!stall_i) begin
            decode_o <= decode_d;
        end
    end

endmodule

// File: verilog/if_stage.sv
/*
 * Instruction fetch stage
 * program counter with branch redirect and the IF/ID register
 */
module if_stage
    import riscv_pkg::*, core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic [XLEN-1:0] reset_addr_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  redirect_t       redirect_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  instr_t          imem_rdata_i,
    output if_id_t          fetch_o
);

    logic [XLEN-1:0] pc_q;

    // redirect wins, it never comes together with a stall
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (!stall_i) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    // instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fetch_o.valid <= 1'b0;
        end else if (flush_i) begin
            fetch_o.valid <= 1'b0;
        end else if (!stall_i) begin
            fetch_o.valid <= 1'b1;
            fetch_o.pc    <= pc_q;
            fetch_o.instr <= imem_rdata_i;
        end
    end

endmodule

// File: verilog/core_pkg.sv
/*
 * Pipeline types of the five-stage core
 * stage registers, hazard control, APB bus and the commit trace
 */
package core_pkg;
    import riscv_pkg::*;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_t          instr;
    } if_id_t;

    // decoded instruction
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  reg_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  branch_ne;
        logic                  is_jal;
    } id_rr_t;

    typedef struct packed {
        id_rr_t          instr;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } rr_exe_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic [XLEN-1:0]       result;
    } exe_wb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } bypass_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic stall_if;
        logic stall_id;
        logic stall_rr;
        logic stall_exe;
    } pipeline_ctrl_t;

    typedef struct packed {
        logic flush_if;
        logic flush_id;
        logic flush_rr;
    } pipeline_flush_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [XLEN-1:0] paddr;
        logic [XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic            pready;
        logic [XLEN-1:0] prdata;
    } apb_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic [XLEN-1:0]       data;
    } commit_t;

endpackage

// File: verilog/riscv_pkg.sv
/*
 * RV32 ISA definitions
 * data widths, major opcodes, funct fields and the ALU operation set
 */
package riscv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [31:0] instr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 values for register-register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

endpackage
